//--- list.f
verilog/bilateral_pkg.sv
verilog/window_fetch.sv
verilog/tap_weighting.sv
verilog/weighted_sum.sv
verilog/weight_divider.sv
verilog/bilateral_filter.sv
tests/tb_clock_gen.sv
tests/bilateral_filter_assertions.sv
tests/bilateral_filter_tb.sv

//--- run.sh
#!/bin/sh
# Build the bilateral filter testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f \
    --top-module bilateral_filter_tb -o bilateral_filter_tb

out=$(./obj_dir/bilateral_filter_tb)
echo "$out"
if echo "$out" | grep -q "TEST PASSED"; then
    exit 0
fi
exit 1

//--- tests/bilateral_filter_assertions.sv
// Concurrent assertions on the bilateral filter top-level ports

`timescale 1ns/1ps
`default_nettype none

module bilateral_filter_assertions import bilateral_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        in_valid_i,
    input pixel_addr_t in_addr_o,
    input logic        out_valid_o,
    input logic        finish_o
);

    int fail_cnt = 0;

    // Outputs idle in the first cycle out of reset
    idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> !out_valid_o && !finish_o)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("out_valid_o or finish_o active in the first cycle after reset");
        end

    // Read address waits for the memory
    addr_hold: assert property (@(posedge clk) disable iff (rst)
        (!in_valid_i && !finish_o) |=> $stable(in_addr_o))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("in_addr_o changed while in_valid_i was low");
        end

    no_output_after_finish: assert property (@(posedge clk) disable iff (rst)
        finish_o |-> !out_valid_o)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("out_valid_o pulsed after finish_o");
        end

endmodule

`default_nettype wire

//--- tests/bilateral_filter_tb.sv
// Bilateral filter testbench
// Frame memory model, two scan passes, reference model, compare tasks and timeout

`timescale 1ns/1ps
`default_nettype none

module bilateral_filter_tb import bilateral_pkg::*; ();

    localparam int SPAN       = PIX_LAST - PIX_FIRST + 1;
    localparam int NUM_OUT    = SPAN * SPAN;
    localparam int MAX_CYCLES = NUM_OUT * WIN_TAPS * 4 + 100;

    logic        clk;
    logic        rst;
    logic        reset_req = 1'b0;
    logic        in_valid = 1'b0;
    pixel_t      in_data;
    pixel_addr_t in_addr;
    logic        out_valid;
    pixel_addr_t out_addr;
    pixel_t      out_data;
    logic        finish;

    pixel_t      frame [0:IMG_SIZE*IMG_SIZE-1];
    pixel_t      first_pass [0:NUM_OUT-1];
    integer      seed;
    int          errors = 0;
    int          out_cnt = 0;
    int          exp_row = PIX_FIRST;
    int          exp_col = PIX_FIRST;
    int          cycle_cnt = 0;
    int          pass_idx = 0;
    logic        random_gaps = 1'b1;

    tb_clock_gen tb_clock_gen_inst (
        .reset_req_i (reset_req),
        .clk_o       (clk),
        .rst_o       (rst)
    );

    bilateral_filter bilateral_filter_inst (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (in_valid),
        .in_data_i   (in_data),
        .in_addr_o   (in_addr),
        .out_valid_o (out_valid),
        .out_addr_o  (out_addr),
        .out_data_o  (out_data),
        .finish_o    (finish)
    );

    bind bilateral_filter bilateral_filter_assertions bilateral_filter_assertions_inst (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (in_valid_i),
        .in_addr_o   (in_addr_o),
        .out_valid_o (out_valid_o),
        .finish_o    (finish_o)
    );

    // Memory answers in the same cycle
    assign in_data = frame[in_addr];

    // Weighted mean over the 3x3 neighbourhood, truncating division
    function automatic pixel_t bilateral_ref(input int row, input int col);
        int range_tab [0:7];
        int num;
        int den;
        int centre;
        int pix;
        int diff;
        int w;
        range_tab = '{16, 12, 8, 5, 3, 2, 1, 1};
        num = 0;
        den = 0;
        centre = int'(frame[pixel_addr_t'(row * IMG_SIZE + col)]);
        for (int dr = -WIN_RADIUS; dr <= WIN_RADIUS; dr++) begin
            for (int dc = -WIN_RADIUS; dc <= WIN_RADIUS; dc++) begin
                pix = int'(frame[pixel_addr_t'((row + dr) * IMG_SIZE + col + dc)]);
                diff = (pix > centre) ? pix - centre : centre - pix;
                // Centre 4, orthogonal 2, corners 1
                w = (dr == 0 && dc == 0) ? 4 : ((dr == 0 || dc == 0) ? 2 : 1);
                w = w * range_tab[3'(diff >> RANGE_SHIFT)];
                num = num + w * pix;
                den = den + w;
            end
        end
        return pixel_t'(num / den);
    endfunction

    task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input pixel_addr_t exp, input pixel_addr_t act);
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s expected 0x%02h actual 0x%02h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            errors++;
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    // Read valid with probability 3/4 in the first pass
    always @(negedge clk) begin
        if (random_gaps) begin
            in_valid <= (($random(seed) & 3) != 0);
        end else begin
            in_valid <= 1'b1;
        end
    end

    always @(negedge clk) begin : compare_outputs
        string tag;
        if (rst) begin
            out_cnt = 0;
            exp_row = PIX_FIRST;
            exp_col = PIX_FIRST;
        end else begin
            if (finish && out_cnt != NUM_OUT) begin
                errors++;
                $display("ERROR: finish_o high after only %0d outputs in pass %0d",
                         out_cnt, pass_idx);
            end
            if (out_valid) begin
                if (out_cnt >= NUM_OUT) begin
                    errors++;
                    $display("ERROR: extra out_valid_o pulse in pass %0d", pass_idx);
                end else begin
                    tag = $sformatf("pass%0d pixel (%0d,%0d)", pass_idx,
                                    out_addr[7:4], out_addr[3:0]);
                    check_addr({tag, " addr"}, {coord_t'(exp_row), coord_t'(exp_col)}, out_addr);
                    check_pixel(tag, bilateral_ref(int'(out_addr[7:4]), int'(out_addr[3:0])),
                                out_data);
                    if (pass_idx == 0) begin
                        first_pass[8'(out_cnt)] = out_data;
                    end else begin
                        check_pixel({tag, " vs pass0"}, first_pass[8'(out_cnt)], out_data);
                    end
                    if (exp_col == PIX_LAST) begin
                        exp_col = PIX_FIRST;
                        exp_row = exp_row + 1;
                    end else begin
                        exp_col = exp_col + 1;
                    end
                end
                out_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= 0;
        end else if (cycle_cnt >= MAX_CYCLES) begin
            $display("ERROR: timeout, finish_o not seen within %0d cycles in pass %0d",
                     MAX_CYCLES, pass_idx);
            $display("TEST FAILED");
            $finish;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    task automatic run_pass(input int idx, input logic gaps);
        pass_idx = idx;
        random_gaps = gaps;
        if (idx > 0) begin
            reset_req = 1'b1;
        end
        @(negedge clk);
        reset_req = 1'b0;
        while (rst) @(negedge clk);
        while (!finish) @(negedge clk);
        check_count($sformatf("pass%0d output count", idx), NUM_OUT, out_cnt);
        // Finish is sticky
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            if (!finish) begin
                errors++;
                $display("ERROR: finish_o dropped in pass %0d", idx);
            end
        end
    endtask

    initial begin
        int assert_fails;
        seed = 32'h1620;
        for (int a = 0; a < IMG_SIZE * IMG_SIZE; a++) begin
            frame[pixel_addr_t'(a)] = pixel_t'($random(seed));
        end
        run_pass(0, 1'b1);
        run_pass(1, 1'b0);
        assert_fails = bilateral_filter_inst.bilateral_filter_assertions_inst.fail_cnt;
        $display("Check errors: %0d, assertion failures: %0d", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
// Testbench clock of 10 ns and a two-cycle reset, repeated on request

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    input  logic reset_req_i,
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset holds for two rising edges and drops on a falling edge
    initial begin
        rst_o = 1'b1;
        forever begin
            repeat (2) @(posedge clk_o);
            @(negedge clk_o);
            rst_o = 1'b0;
            @(posedge reset_req_i);
            rst_o = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/bilateral_filter.sv
// Bilateral filter top level
// Fetch, tap weighting, window sums and division chained in order

`timescale 1ns/1ps
`default_nettype none

module bilateral_filter import bilateral_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid_i,
    input  pixel_t      in_data_i,
    output pixel_addr_t in_addr_o,
    output logic        out_valid_o,
    output pixel_addr_t out_addr_o,
    output pixel_t      out_data_o,
    output logic        finish_o
);

    window_t        win;
    logic           win_valid;
    weighted_taps_t taps;
    logic           taps_valid;
    window_sums_t   sums;
    logic           sums_valid;

    window_fetch window_fetch_inst (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (in_valid_i),
        .in_data_i   (in_data_i),
        .in_addr_o   (in_addr_o),
        .win_o       (win),
        .win_valid_o (win_valid)
    );

    tap_weighting tap_weighting_inst (
        .clk          (clk),
        .rst          (rst),
        .win_i        (win),
        .win_valid_i  (win_valid),
        .taps_o       (taps),
        .taps_valid_o (taps_valid)
    );

    weighted_sum weighted_sum_inst (
        .clk          (clk),
        .rst          (rst),
        .taps_i       (taps),
        .taps_valid_i (taps_valid),
        .sums_o       (sums),
        .sums_valid_o (sums_valid)
    );

    // Busy for nine cycles, shorter than any window fetch
    weight_divider weight_divider_inst (
        .clk          (clk),
        .rst          (rst),
        .sums_i       (sums),
        .sums_valid_i (sums_valid),
        .out_valid_o  (out_valid_o),
        .out_addr_o   (out_addr_o),
        .out_data_o   (out_data_o),
        .finish_o     (finish_o)
    );

endmodule

`default_nettype wire

//--- verilog/bilateral_pkg.sv
// Frame geometry constants, vector types and stage structs of the bilateral filter
// Spatial and range weight tables

`default_nettype none

package bilateral_pkg;

    localparam int IMG_SIZE    = 16;
    localparam int WIN_RADIUS  = 1;
    localparam int WIN_TAPS    = 9;
    localparam int CENTRE_TAP  = WIN_TAPS / 2;
    localparam int PIX_FIRST   = 1;
    localparam int PIX_LAST    = 14;
    localparam int RANGE_SHIFT = 5;
    localparam int QUOT_BITS   = 8;

    typedef logic [7:0]                  pixel_t;
    typedef logic [$clog2(IMG_SIZE)-1:0] coord_t;
    // Row in the upper half, column in the lower half
    typedef logic [2*$bits(coord_t)-1:0] pixel_addr_t;
    typedef logic [6:0]                  weight_t;
    typedef logic [9:0]                  weight_sum_t;
    typedef logic [17:0]                 acc_t;

    typedef struct packed {
        pixel_t [WIN_TAPS-1:0] pix;
        pixel_addr_t           addr;
        logic                  last;
    } window_t;

    typedef struct packed {
        pixel_t  [WIN_TAPS-1:0] pix;
        weight_t [WIN_TAPS-1:0] wgt;
        pixel_addr_t            addr;
        logic                   last;
    } weighted_taps_t;

    typedef struct packed {
        acc_t        num;
        weight_sum_t den;
        pixel_addr_t addr;
        logic        last;
    } window_sums_t;

    typedef enum logic [1:0] {
        FETCH_SCAN,
        FETCH_WAIT,
        FETCH_DONE
    } fetch_state_t;

    // Odd taps of the row-major 3x3 window are the orthogonal neighbours
    function automatic weight_t spatial_weight(input int tap);
        if (tap == CENTRE_TAP) begin
            return 7'd4;
        end else if (tap % 2 == 1) begin
            return 7'd2;
        end
        return 7'd1;
    endfunction

    function automatic weight_t range_weight(input logic [2:0] idx);
        case (idx)
            3'd0:    return 7'd16;
            3'd1:    return 7'd12;
            3'd2:    return 7'd8;
            3'd3:    return 7'd5;
            3'd4:    return 7'd3;
            3'd5:    return 7'd2;
            default: return 7'd1;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- verilog/tap_weighting.sv
// Per-tap bilateral weight, spatial weight times range weight
// Registers the taps together with their weights

`timescale 1ns/1ps
`default_nettype none

module tap_weighting import bilateral_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  window_t        win_i,
    input  logic           win_valid_i,
    output weighted_taps_t taps_o,
    output logic           taps_valid_o
);

    pixel_t  [WIN_TAPS-1:0] diff_c;
    weight_t [WIN_TAPS-1:0] wgt_c;

    always_comb begin
        for (int i = 0; i < WIN_TAPS; i++) begin
            // Absolute distance from the centre intensity
            if (win_i.pix[i] > win_i.pix[CENTRE_TAP]) begin
                diff_c[i] = win_i.pix[i] - win_i.pix[CENTRE_TAP];
            end else begin
                diff_c[i] = win_i.pix[CENTRE_TAP] - win_i.pix[i];
            end
            // Coarse distance selects the range table entry
            wgt_c[i] = spatial_weight(i) * range_weight(3'(diff_c[i] >> RANGE_SHIFT));
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            taps_valid_o <= 1'b0;
        end else begin
            taps_valid_o <= win_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (win_valid_i) begin
            taps_o.pix  <= win_i.pix;
            taps_o.wgt  <= wgt_c;
            taps_o.addr <= win_i.addr;
            taps_o.last <= win_i.last;
        end
    end

endmodule

`default_nettype wire

//--- verilog/weight_divider.sv
// Restoring divider, one quotient bit per cycle
// Drives the filtered pixel strobe and the sticky finish flag

`timescale 1ns/1ps
`default_nettype none

module weight_divider import bilateral_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  window_sums_t sums_i,
    input  logic         sums_valid_i,
    output logic         out_valid_o,
    output pixel_addr_t  out_addr_o,
    output pixel_t       out_data_o,
    output logic         finish_o
);

    logic [$clog2(QUOT_BITS)-1:0] iter_cnt;
    logic                         busy_r;
    acc_t                         rem_r;
    acc_t                         dsr_r;
    pixel_t                       quot_r;
    pixel_addr_t                  addr_r;
    logic                         last_r;
    logic [$bits(acc_t):0]        trial;
    logic                         q_bit;

    // Borrow out means the divisor does not fit, remainder is kept
    assign trial = {1'b0, rem_r} - {1'b0, dsr_r};
    assign q_bit = ~trial[$bits(acc_t)];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_r      <= 1'b0;
            iter_cnt    <= '0;
            out_valid_o <= 1'b0;
            out_addr_o  <= '0;
            out_data_o  <= '0;
            finish_o    <= 1'b0;
        end else begin
            out_valid_o <= 1'b0;
            if (sums_valid_i) begin
                busy_r   <= 1'b1;
                iter_cnt <= '0;
            end else if (busy_r) begin
                iter_cnt <= iter_cnt + 1'b1;
                if (int'(iter_cnt) == QUOT_BITS - 1) begin
                    busy_r      <= 1'b0;
                    out_valid_o <= 1'b1;
                    out_addr_o  <= addr_r;
                    out_data_o  <= {quot_r[QUOT_BITS-2:0], q_bit};
                end
            end
            // Sticky until reset
            if (out_valid_o && last_r) begin
                finish_o <= 1'b1;
            end
        end
    end

    // Divisor starts aligned with the quotient MSB
    always_ff @(posedge clk) begin
        if (sums_valid_i) begin
            rem_r  <= sums_i.num;
            dsr_r  <= acc_t'(sums_i.den) << (QUOT_BITS - 1);
            quot_r <= '0;
            addr_r <= sums_i.addr;
            last_r <= sums_i.last;
        end else if (busy_r) begin
            if (q_bit) begin
                rem_r <= trial[$bits(acc_t)-1:0];
            end
            dsr_r  <= dsr_r >> 1;
            quot_r <= {quot_r[QUOT_BITS-2:0], q_bit};
        end
    end

endmodule

`default_nettype wire

//--- verilog/weighted_sum.sv
// Window sums, weight times pixel and the weights alone
// One registered stage

`timescale 1ns/1ps
`default_nettype none

module weighted_sum import bilateral_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  weighted_taps_t taps_i,
    input  logic           taps_valid_i,
    output window_sums_t   sums_o,
    output logic           sums_valid_o
);

    acc_t        num_c;
    weight_sum_t den_c;

    // At most 256 * 255 in the numerator
    always_comb begin
        num_c = '0;
        den_c = '0;
        for (int i = 0; i < WIN_TAPS; i++) begin
            num_c = num_c + acc_t'(taps_i.wgt[i]) * acc_t'(taps_i.pix[i]);
            den_c = den_c + weight_sum_t'(taps_i.wgt[i]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sums_valid_o <= 1'b0;
        end else begin
            sums_valid_o <= taps_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (taps_valid_i) begin
            sums_o.num  <= num_c;
            sums_o.den  <= den_c;
            sums_o.addr <= taps_i.addr;
            sums_o.last <= taps_i.last;
        end
    end

endmodule

`default_nettype wire

//--- verilog/window_fetch.sv
// Output position scan and 3x3 window fetch
// Drives the frame read address and gathers nine taps per centre pixel

`timescale 1ns/1ps
`default_nettype none

module window_fetch import bilateral_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid_i,
    input  pixel_t      in_data_i,
    output pixel_addr_t in_addr_o,
    output window_t     win_o,
    output logic        win_valid_o
);

    fetch_state_t state_r;
    coord_t       row_r;
    coord_t       col_r;
    logic [3:0]   tap_cnt;
    logic [1:0]   tap_dr;
    logic [1:0]   tap_dc;
    logic         accept;
    logic         tap_last;
    logic         centre_last;

    assign accept      = in_valid_i && (state_r != FETCH_DONE);
    assign tap_last    = (tap_cnt == 4'(WIN_TAPS - 1));
    assign centre_last = (row_r == coord_t'(PIX_LAST)) && (col_r == coord_t'(PIX_LAST));

    // Centre plus the tap offset within the window
    assign in_addr_o = {coord_t'(row_r + coord_t'(tap_dr) - coord_t'(WIN_RADIUS)),
                        coord_t'(col_r + coord_t'(tap_dc) - coord_t'(WIN_RADIUS))};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_r     <= FETCH_SCAN;
            row_r       <= coord_t'(PIX_FIRST);
            col_r       <= coord_t'(PIX_FIRST);
            tap_cnt     <= '0;
            tap_dr      <= '0;
            tap_dc      <= '0;
            win_valid_o <= 1'b0;
        end else begin
            win_valid_o <= 1'b0;
            case (state_r)
                FETCH_SCAN, FETCH_WAIT: begin
                    if (accept) begin
                        state_r <= FETCH_SCAN;
                        if (tap_last) begin
                            tap_cnt     <= '0;
                            tap_dr      <= '0;
                            tap_dc      <= '0;
                            win_valid_o <= 1'b1;
                            if (centre_last) begin
                                state_r <= FETCH_DONE;
                            end else if (col_r == coord_t'(PIX_LAST)) begin
                                col_r <= coord_t'(PIX_FIRST);
                                row_r <= row_r + 1'b1;
                            end else begin
                                col_r <= col_r + 1'b1;
                            end
                        end else begin
                            tap_cnt <= tap_cnt + 1'b1;
                            if (tap_dc == 2'(2 * WIN_RADIUS)) begin
                                tap_dc <= '0;
                                tap_dr <= tap_dr + 1'b1;
                            end else begin
                                tap_dc <= tap_dc + 1'b1;
                            end
                        end
                    end else begin
                        // Address holds until the memory returns data
                        state_r <= FETCH_WAIT;
                    end
                end
                default: begin
                    state_r <= FETCH_DONE;
                end
            endcase
        end
    end

    // Slots are overwritten only after downstream has sampled the window
    always_ff @(posedge clk) begin
        if (accept) begin
            win_o.pix[tap_cnt] <= in_data_i;
            if (tap_last) begin
                win_o.addr <= {row_r, col_r};
                win_o.last <= centre_last;
            end
        end
    end

endmodule

`default_nettype wire
